//--- list.f
+incdir+verilog
verilog/rvc_pkg.sv
verilog/rvc_expand_if.sv
verilog/rvc_mem_expander.sv
verilog/rvc_alu_expander.sv
verilog/rvc_encoder.sv
verilog/rvc_decompressor.sv
testbench/rvc_checker.sv
testbench/rvc_tb.sv

//--- testbench/rvc_checker.sv
`timescale 1ns/1ns

module rvc_checker (
	input logic clk_i,
	input logic rst_i,
	input logic valid_i,
	input logic [31:0] instr_i,
	input logic valid_o,
	input logic [31:0] instr_o,
	input logic compressed_o,
	input logic illegal_o,
	output int checks_o,
	output int errors_o
);

	// set after the first rising edge since outputs are unknown before it
	logic primed;
	// reset seen and no word accepted yet
	logic quiet;
	logic exp_valid;
	// {illegal, compressed, word}
	logic [33:0] exp_res;

	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
		input logic [6:0] opc);
		r_type = {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		i_type = {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] opc);
		s_type = {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
	endfunction

	// byte offset with bit 0 dropped
	function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] opc);
		b_type = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		u_type = {imm, rd, opc};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd,
		input logic [6:0] opc);
		j_type = {off[20], off[10:1], off[11], off[19:12], rd, opc};
	endfunction

	// expected result of one fetch word on an rv64 core
	function automatic logic [33:0] expand_ref(input logic [31:0] w);
		logic [15:0] c;
		logic [4:0] rd;
		logic [4:0] rs2;
		logic [4:0] rdp;
		logic [4:0] rs1p;
		logic [11:0] simm;
		logic [20:0] joff;
		logic [12:0] boff;
		logic [31:0] res;
		logic bad;
		c = w[15:0];
		rd = c[11:7];
		rs2 = c[6:2];
		// x8 based register forms
		rdp = 5'd8 + c[4:2];
		rs1p = 5'd8 + c[9:7];
		simm = {{6{c[12]}}, c[12], c[6:2]};
		joff = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
		boff = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
		res = '0;
		bad = 1'b0;
		if (w[1:0] == 2'b11) begin
			return {1'b0, 1'b0, w};
		end
		case ({c[1:0], c[15:13]})
			5'b00_000: begin
				bad = (c == 16'h0000);
				res = i_type({2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00}, 5'd2, 3'b000, rdp,
					7'h13);
			end
			5'b00_010: res = i_type({5'b0, c[5], c[12:10], c[6], 2'b00}, rs1p, 3'b010, rdp, 7'h03);
			5'b00_011: res = i_type({4'b0, c[6:5], c[12:10], 3'b000}, rs1p, 3'b011, rdp, 7'h03);
			5'b00_110: res = s_type({5'b0, c[5], c[12:10], c[6], 2'b00}, rdp, rs1p, 3'b010, 7'h23);
			5'b00_111: res = s_type({4'b0, c[6:5], c[12:10], 3'b000}, rdp, rs1p, 3'b011, 7'h23);
			5'b01_000: res = i_type(simm, rd, 3'b000, rd, 7'h13);
			// addiw on rv64
			5'b01_001: res = i_type(simm, rd, 3'b000, rd, 7'h1b);
			5'b01_010: res = i_type(simm, 5'd0, 3'b000, rd, 7'h13);
			5'b01_011: begin
				if (rd == 5'd2) begin
					res = i_type({{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000}, 5'd2, 3'b000,
						5'd2, 7'h13);
				end else begin
					res = u_type({{8{simm[11]}}, simm}, rd, 7'h37);
				end
			end
			5'b01_100: begin
				case (c[11:10])
					2'b00: res = i_type({6'b0, c[12], c[6:2]}, rs1p, 3'b101, rs1p, 7'h13);
					2'b01: res = i_type({6'b010000, c[12], c[6:2]}, rs1p, 3'b101, rs1p, 7'h13);
					2'b10: res = i_type(simm, rs1p, 3'b111, rs1p, 7'h13);
					default: begin
						case ({c[12], c[6:5]})
							3'b000: res = r_type(7'h20, rdp, rs1p, 3'b000, rs1p, 7'h33);
							3'b001: res = r_type(7'h00, rdp, rs1p, 3'b100, rs1p, 7'h33);
							3'b010: res = r_type(7'h00, rdp, rs1p, 3'b110, rs1p, 7'h33);
							3'b011: res = r_type(7'h00, rdp, rs1p, 3'b111, rs1p, 7'h33);
							3'b100: res = r_type(7'h20, rdp, rs1p, 3'b000, rs1p, 7'h3b);
							3'b101: res = r_type(7'h00, rdp, rs1p, 3'b000, rs1p, 7'h3b);
							// zcb mul and unary ops
							default: bad = 1'b1;
						endcase
					end
				endcase
			end
			5'b01_101: res = j_type(joff, 5'd0, 7'h6f);
			5'b01_110: res = b_type(boff, 5'd0, rs1p, 3'b000, 7'h63);
			5'b01_111: res = b_type(boff, 5'd0, rs1p, 3'b001, 7'h63);
			5'b10_000: res = i_type({6'b0, c[12], c[6:2]}, rd, 3'b001, rd, 7'h13);
			5'b10_010: res = i_type({4'b0, c[3:2], c[12], c[6:4], 2'b00}, 5'd2, 3'b010, rd, 7'h03);
			5'b10_011: res = i_type({3'b0, c[4:2], c[12], c[6:5], 3'b000}, 5'd2, 3'b011, rd, 7'h03);
			5'b10_100: begin
				if (rs2 != 5'd0) begin
					// mv adds to x0, add to rd
					res = r_type(7'h00, rs2, c[12] ? rd : 5'd0, 3'b000, rd, 7'h33);
				end else if (rd != 5'd0) begin
					res = i_type(12'h000, rd, 3'b000, c[12] ? 5'd1 : 5'd0, 7'h67);
				end else if (c[12]) begin
					res = 32'h0010_0073;
				end else begin
					bad = 1'b1;
				end
			end
			5'b10_110: res = s_type({4'b0, c[8:7], c[12:9], 2'b00}, rs2, 5'd2, 3'b010, 7'h23);
			5'b10_111: res = s_type({3'b0, c[9:7], c[12:10], 3'b000}, rs2, 5'd2, 3'b011, 7'h23);
			// float slots and the zcb load store slot
			default: bad = 1'b1;
		endcase
		return {bad, 1'b1, res};
	endfunction

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks_o++;
		if (actual !== expected) begin
			errors_o++;
			$display("FAIL t=%0t %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks_o++;
		if (actual !== expected) begin
			errors_o++;
			$display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	initial begin
		checks_o = 0;
		errors_o = 0;
		primed = 1'b0;
		quiet = 1'b0;
		exp_valid = 1'b0;
		exp_res = '0;
	end

	// one stage model on the same edge the dut registers on
	always @(posedge clk_i) begin
		primed <= 1'b1;
		exp_res <= expand_ref(instr_i);
		if (rst_i) begin
			exp_valid <= 1'b0;
			quiet <= 1'b1;
		end else begin
			exp_valid <= valid_i;
			if (valid_i) begin
				quiet <= 1'b0;
			end
		end
	end

	// outputs settled half a cycle after the rising edge
	always @(negedge clk_i) begin
		if (primed) begin
			if (quiet) begin
				check_bit("compressed_o", 1'b0, compressed_o);
				check_bit("illegal_o", 1'b0, illegal_o);
			end
			// valid_o must trail valid_i by exactly one cycle
			if (valid_o !== exp_valid) begin
				errors_o++;
				$display("FAIL t=%0t valid_o expected %b got %b", $time, exp_valid, valid_o);
			end
			if (exp_valid) begin
				check_bit("compressed_o", exp_res[32], compressed_o);
				check_bit("illegal_o", exp_res[33], illegal_o);
				// word is undefined for illegal encodings
				if (!exp_res[33]) begin
					check_word("instr_o", exp_res[31:0], instr_o);
				end
			end
		end
	end

endmodule

//--- testbench/rvc_tb.sv
`timescale 1ns/1ns

module rvc_tb;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int RANDOM_WORDS = 400;
	// directed, illegal and pass-through words
	localparam int FIXED_WORDS = 32 + 9 + 4;
	// a gapped word costs up to four cycles and every test drains for three
	localparam int RUN_CYCLES = RESET_CYCLES + FIXED_WORDS + RANDOM_WORDS * 5 + 6 * 3 + 200;

	logic clk_i;
	logic rst_i;
	logic valid_i;
	logic [31:0] instr_i;
	logic valid_o;
	logic [31:0] instr_o;
	logic compressed_o;
	logic illegal_o;

	// running totals from the checker
	int checks;
	int errors;
	int mark_checks;
	int mark_errors;
	int empty_tests;

	logic [31:0] lfsr_state;
	logic [31:0] rnd_word;
	logic [31:0] gap;

	rvc_decompressor rvc_decompressor_inst (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.valid_i(valid_i),
		.instr_i(instr_i),
		.valid_o(valid_o),
		.instr_o(instr_o),
		.compressed_o(compressed_o),
		.illegal_o(illegal_o)
	);

	rvc_checker rvc_checker_inst (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.valid_i(valid_i),
		.instr_i(instr_i),
		.valid_o(valid_o),
		.instr_o(instr_o),
		.compressed_o(compressed_o),
		.illegal_o(illegal_o),
		.checks_o(checks),
		.errors_o(errors)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	// right shift galois form with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			lfsr_next = (s >> 1) ^ 32'h8020_0003;
		end else begin
			lfsr_next = s >> 1;
		end
	endfunction

	// one lfsr step per bit taken
	task automatic random_bits(input int n, output logic [31:0] val);
		int i;
		val = '0;
		for (i = 0; i < n; i++) begin
			val = {val[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// called on a falling edge and returns on the next one
	task automatic send_word(input logic [31:0] w);
		valid_i = 1'b1;
		instr_i = w;
		@(negedge clk_i);
	endtask

	// upper half is noise since the expander only looks at [15:0]
	task automatic send_c(input logic [15:0] c);
		send_word({16'ha55a, c});
	endtask

	task automatic idle(input int n);
		valid_i = 1'b0;
		repeat (n) @(negedge clk_i);
	endtask

	// drain the pipe and then read the checker counts away from its falling edge
	task automatic close_test(input string name);
		int new_checks;
		int new_errors;
		idle(3);
		@(posedge clk_i);
		new_checks = checks - mark_checks;
		new_errors = errors - mark_errors;
		if (new_checks == 0) begin
			empty_tests++;
			$display("test %s: no results were checked", name);
		end else begin
			$display("test %s: %0d checks, %0d errors, %s", name, new_checks, new_errors,
				new_errors == 0 ? "ok" : "mismatch");
		end
		mark_checks = checks;
		mark_errors = errors;
		@(negedge clk_i);
	endtask

	initial begin
		rst_i = 1'b1;
		// an illegal compressed word offered during reset must never come out
		valid_i = 1'b1;
		instr_i = '0;
		lfsr_state = 32'he3ad_6142;
		mark_checks = 0;
		mark_errors = 0;
		empty_tests = 0;
		repeat (RESET_CYCLES) @(negedge clk_i);
		rst_i = 1'b0;
		close_test("reset");

		// addi4spn, lw, ld, sw and sd in quadrant 0
		send_c({3'b000, 8'b1010_0101, 3'b001, 2'b00});
		send_c({3'b010, 3'b101, 3'b010, 2'b11, 3'b100, 2'b00});
		send_c({3'b011, 3'b011, 3'b110, 2'b10, 3'b001, 2'b00});
		send_c({3'b110, 3'b100, 3'b011, 2'b01, 3'b111, 2'b00});
		send_c({3'b111, 3'b001, 3'b000, 2'b11, 3'b010, 2'b00});
		// addi, addiw, li, addi16sp and lui in quadrant 1
		send_c({3'b000, 1'b1, 5'd10, 5'b10011, 2'b01});
		send_c({3'b001, 1'b0, 5'd11, 5'b00101, 2'b01});
		send_c({3'b010, 1'b1, 5'd12, 5'b11111, 2'b01});
		send_c({3'b011, 1'b1, 5'd2, 5'b10110, 2'b01});
		send_c({3'b011, 1'b0, 5'd13, 5'b01010, 2'b01});
		// srli, srai, andi
		send_c({3'b100, 1'b1, 2'b00, 3'b010, 5'b00111, 2'b01});
		send_c({3'b100, 1'b0, 2'b01, 3'b011, 5'b11000, 2'b01});
		send_c({3'b100, 1'b1, 2'b10, 3'b100, 5'b01110, 2'b01});
		// sub, xor, or, and, subw, addw
		send_c({3'b100, 1'b0, 2'b11, 3'b001, 2'b00, 3'b110, 2'b01});
		send_c({3'b100, 1'b0, 2'b11, 3'b010, 2'b01, 3'b101, 2'b01});
		send_c({3'b100, 1'b0, 2'b11, 3'b011, 2'b10, 3'b100, 2'b01});
		send_c({3'b100, 1'b0, 2'b11, 3'b100, 2'b11, 3'b011, 2'b01});
		send_c({3'b100, 1'b1, 2'b11, 3'b101, 2'b00, 3'b010, 2'b01});
		send_c({3'b100, 1'b1, 2'b11, 3'b110, 2'b01, 3'b001, 2'b01});
		// j, beqz, bnez
		send_c({3'b101, 11'b101_1001_1010, 2'b01});
		send_c({3'b110, 3'b011, 3'b101, 5'b10110, 2'b01});
		send_c({3'b111, 3'b100, 3'b010, 5'b01001, 2'b01});
		// slli, lwsp and ldsp in quadrant 2
		send_c({3'b000, 1'b1, 5'd14, 5'b00011, 2'b10});
		send_c({3'b010, 1'b0, 5'd15, 5'b10101, 2'b10});
		send_c({3'b011, 1'b1, 5'd16, 5'b01110, 2'b10});
		// jr, mv, jalr, add, ebreak
		send_c({3'b100, 1'b0, 5'd17, 5'd0, 2'b10});
		send_c({3'b100, 1'b0, 5'd18, 5'd19, 2'b10});
		send_c({3'b100, 1'b1, 5'd20, 5'd0, 2'b10});
		send_c({3'b100, 1'b1, 5'd21, 5'd22, 2'b10});
		send_c({3'b100, 1'b1, 5'd0, 5'd0, 2'b10});
		// swsp, sdsp
		send_c({3'b110, 6'b101101, 5'd23, 2'b10});
		send_c({3'b111, 6'b011010, 5'd24, 2'b10});
		close_test("directed");

		// all zero, fld, fsd, zcb loads and stores
		send_c(16'h0000);
		send_c({3'b001, 3'b010, 3'b011, 2'b01, 3'b100, 2'b00});
		send_c({3'b101, 3'b110, 3'b001, 2'b10, 3'b010, 2'b00});
		send_c({3'b100, 3'b001, 3'b010, 2'b11, 3'b001, 2'b00});
		// zcb mul and unary group
		send_c({3'b100, 1'b1, 2'b11, 3'b010, 2'b10, 3'b001, 2'b01});
		send_c({3'b100, 1'b1, 2'b11, 3'b011, 2'b11, 3'b000, 2'b01});
		// fldsp, fsdsp, jr x0
		send_c({3'b001, 1'b0, 5'd8, 5'b01100, 2'b10});
		send_c({3'b101, 6'b010011, 5'd9, 2'b10});
		send_c({3'b100, 1'b0, 5'd0, 5'd0, 2'b10});
		close_test("illegal");

		// full 32-bit add, addi, lui and nop words
		send_word(32'h00a5_0533);
		send_word(32'hfff0_0093);
		send_word(32'h1234_5677);
		send_word(32'h0000_0013);
		close_test("passthrough");

		repeat (RANDOM_WORDS) begin
			random_bits(32, rnd_word);
			send_word(rnd_word);
		end
		close_test("back-to-back");

		// zero to three idle cycles after each word
		repeat (RANDOM_WORDS) begin
			random_bits(32, rnd_word);
			send_word(rnd_word);
			random_bits(2, gap);
			idle(int'(gap));
		end
		close_test("random gaps");

		@(posedge clk_i);
		$display("summary: %0d checks, %0d errors, %0d tests without results", checks, errors,
			empty_tests);
		if (errors == 0 && empty_tests == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the test sequence did not complete",
			RUN_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- verilog/rvc_alu_expander.sv
`timescale 1ns/1ns
`include "rvc_settings.svh"

module rvc_alu_expander
	import rvc_pkg::*;
#(
	parameter bit RV64 = `RVC_RV64_DEFAULT
) (
	input cinstr_t instr_i,
	rvc_expand_if.expander exp
);

	logic [1:0] quad;
	logic [2:0] f3;

	reg_idx_t rd_full;
	// x8..x15 forms for the register-register group
	reg_idx_t rd_c;
	reg_idx_t rs2_c;

	// 6-bit immediate, sign extended to the container
	// also serves c.lui since U keeps imm[31:12]
	imm_t imm6_s;
	// jump offset[20:1]
	imm_t imm_j;
	// branch offset[12:1]
	imm_t imm_b;
	// c.addi16sp, multiples of 16
	imm_t imm_16sp;

	assign quad = instr_i[1:0];
	assign f3 = instr_i[15:13];

	assign rd_full = instr_i[11:7];
	assign rd_c = {2'b01, instr_i[9:7]};
	assign rs2_c = {2'b01, instr_i[4:2]};

	assign imm6_s = {{14{instr_i[12]}}, instr_i[12], instr_i[6:2]};
	assign imm_j = {{9{instr_i[12]}}, instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
		instr_i[7], instr_i[2], instr_i[11], instr_i[5:3]};
	assign imm_b = {{12{instr_i[12]}}, instr_i[12], instr_i[6:5], instr_i[2],
		instr_i[11:10], instr_i[4:3]};
	assign imm_16sp = {{10{instr_i[12]}}, instr_i[12], instr_i[4:3], instr_i[5], instr_i[2],
		instr_i[6], 4'b0000};

	always_comb begin
		exp.claim = (quad == 2'b01);
		exp.illegal = 1'b0;
		// c.addi shape unless a slot says otherwise
		exp.fmt = fmt_i;
		exp.opcode = opc_op_imm;
		exp.funct3 = 3'b000;
		exp.funct7 = '0;
		exp.rd = rd_full;
		exp.rs1 = rd_full;
		exp.rs2 = '0;
		exp.imm = imm6_s;

		case (f3)
			// c.addi
			3'b000: exp.opcode = opc_op_imm;
			3'b001: begin
				if (RV64) begin
					// c.addiw
					exp.opcode = opc_op_imm32;
				end else begin
					// c.jal, rv32 only
					exp.fmt = fmt_j;
					exp.opcode = opc_jal;
					exp.rd = reg_idx_t'(`RVC_RA_IDX);
					exp.imm = imm_j;
				end
			end
			// c.li adds to x0
			3'b010: exp.rs1 = '0;
			3'b011: begin
				if (rd_full == reg_idx_t'(`RVC_SP_IDX)) begin
					// c.addi16sp
					exp.imm = imm_16sp;
				end else begin
					// c.lui
					exp.fmt = fmt_u;
					exp.opcode = opc_lui;
				end
			end
			3'b100: begin
				exp.rd = rd_c;
				exp.rs1 = rd_c;
				case (instr_i[11:10])
					2'b00: begin
						// c.srli
						exp.funct3 = 3'b101;
						exp.imm = imm_t'({instr_i[12], instr_i[6:2]});
					end
					2'b01: begin
						// c.srai, bit 30 set
						exp.funct3 = 3'b101;
						exp.imm = imm_t'({6'b010000, instr_i[12], instr_i[6:2]});
					end
					// c.andi
					2'b10: exp.funct3 = 3'b111;
					default: begin
						exp.fmt = fmt_r;
						exp.opcode = opc_op;
						exp.rs2 = rs2_c;
						if (!instr_i[12]) begin
							// c.sub, c.xor, c.or, c.and
							exp.funct3 = {|instr_i[6:5], instr_i[6], &instr_i[6:5]};
							exp.funct7 = {1'b0, instr_i[6:5] == 2'b00, 5'b00000};
						end else if (!instr_i[6]) begin
							// c.subw, c.addw
							exp.opcode = opc_op32;
							exp.funct7 = {1'b0, ~instr_i[5], 5'b00000};
							exp.illegal = !RV64;
						end else begin
							// zcb mul and unary slot
							exp.illegal = 1'b1;
						end
					end
				endcase
			end
			3'b101: begin
				// c.j, no link
				exp.fmt = fmt_j;
				exp.opcode = opc_jal;
				exp.rd = '0;
				exp.imm = imm_j;
			end
			default: begin
				// c.beqz, c.bnez compare against x0
				exp.fmt = fmt_b;
				exp.opcode = opc_branch;
				exp.funct3 = {2'b00, f3[0]};
				exp.rs1 = rd_c;
				exp.imm = imm_b;
			end
		endcase
	end

endmodule

//--- verilog/rvc_decompressor.sv
`timescale 1ns/1ns
`include "rvc_settings.svh"

module rvc_decompressor
	import rvc_pkg::*;
#(
	parameter bit RV64 = `RVC_RV64_DEFAULT
) (
	input logic clk_i,
	input logic rst_i,
	input logic valid_i,
	input instr_t instr_i,
	output logic valid_o,
	output instr_t instr_o,
	output logic compressed_o,
	output logic illegal_o
);

	// one field bundle per expander
	rvc_expand_if mem_if ();
	rvc_expand_if alu_if ();

	// quadrants 0 and 2, loads, stores, jumps through registers
	rvc_mem_expander #(
		.RV64(RV64)
	) mem_expander_inst (
		.instr_i(instr_i[`RVC_CINSTR_W-1:0]),
		.exp(mem_if.expander)
	);

	// quadrant 1, arithmetic and control flow
	rvc_alu_expander #(
		.RV64(RV64)
	) alu_expander_inst (
		.instr_i(instr_i[`RVC_CINSTR_W-1:0]),
		.exp(alu_if.expander)
	);

	// packing and the single output register stage
	rvc_encoder encoder_inst (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.valid_i(valid_i),
		.instr_i(instr_i),
		.mem(mem_if.encoder),
		.alu(alu_if.encoder),
		.valid_o(valid_o),
		.instr_o(instr_o),
		.compressed_o(compressed_o),
		.illegal_o(illegal_o)
	);

endmodule

//--- verilog/rvc_encoder.sv
`timescale 1ns/1ns

module rvc_encoder
	import rvc_pkg::*;
(
	input logic clk_i,
	input logic rst_i,
	input logic valid_i,
	input instr_t instr_i,
	rvc_expand_if.encoder mem,
	rvc_expand_if.encoder alu,
	output logic valid_o,
	output instr_t instr_o,
	output logic compressed_o,
	output logic illegal_o
);

	// fields of the expander that claimed the word
	format_e sel_fmt;
	opcode_e sel_opcode;
	reg_idx_t sel_rd;
	reg_idx_t sel_rs1;
	reg_idx_t sel_rs2;
	funct3_t sel_funct3;
	funct7_t sel_funct7;
	imm_t sel_imm;
	logic sel_illegal;

	// no claim means the low bits were 11
	logic claimed;
	instr_t packed_word;
	instr_t next_word;

	assign claimed = mem.claim | alu.claim;

	// quadrants are disjoint, at most one claim
	always_comb begin
		if (mem.claim) begin
			sel_fmt = mem.fmt;
			sel_opcode = mem.opcode;
			sel_rd = mem.rd;
			sel_rs1 = mem.rs1;
			sel_rs2 = mem.rs2;
			sel_funct3 = mem.funct3;
			sel_funct7 = mem.funct7;
			sel_imm = mem.imm;
			sel_illegal = mem.illegal;
		end else begin
			sel_fmt = alu.fmt;
			sel_opcode = alu.opcode;
			sel_rd = alu.rd;
			sel_rs1 = alu.rs1;
			sel_rs2 = alu.rs2;
			sel_funct3 = alu.funct3;
			sel_funct7 = alu.funct7;
			sel_imm = alu.imm;
			sel_illegal = alu.claim & alu.illegal;
		end
	end

	always_comb begin
		case (sel_fmt)
			fmt_r: packed_word = {sel_funct7, sel_rs2, sel_rs1, sel_funct3, sel_rd, sel_opcode,
				2'b11};
			fmt_i: packed_word = {sel_imm[11:0], sel_rs1, sel_funct3, sel_rd, sel_opcode, 2'b11};
			fmt_s: packed_word = {sel_imm[11:5], sel_rs2, sel_rs1, sel_funct3, sel_imm[4:0],
				sel_opcode, 2'b11};
			// offset[12|10:5] high, offset[4:1|11] low
			fmt_b: packed_word = {sel_imm[11], sel_imm[9:4], sel_rs2, sel_rs1, sel_funct3,
				sel_imm[3:0], sel_imm[10], sel_opcode, 2'b11};
			fmt_u: packed_word = {sel_imm, sel_rd, sel_opcode, 2'b11};
			// offset[20|10:1|11|19:12]
			fmt_j: packed_word = {sel_imm[19], sel_imm[9:0], sel_imm[10], sel_imm[18:11], sel_rd,
				sel_opcode, 2'b11};
			default: packed_word = '0;
		endcase
	end

	// uncompressed words go through untouched
	assign next_word = claimed ? packed_word : instr_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_o <= 1'b0;
			compressed_o <= 1'b0;
			illegal_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
			if (valid_i) begin
				compressed_o <= claimed;
				illegal_o <= sel_illegal;
			end
		end
	end

	// result word, only meaningful with valid_o
	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			instr_o <= next_word;
		end
	end

endmodule

//--- verilog/rvc_expand_if.sv
`timescale 1ns/1ns

interface rvc_expand_if
	import rvc_pkg::*;
();

	// expander recognised its own quadrant
	logic claim;
	// reserved or unsupported slot inside that quadrant
	logic illegal;

	format_e fmt;
	opcode_e opcode;

	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;

	funct3_t funct3;
	funct7_t funct7;

	// already scaled and extended, only bit placement left
	imm_t imm;

	modport expander (
		output claim, illegal, fmt, opcode,
		output rd, rs1, rs2, funct3, funct7, imm
	);

	modport encoder (
		input claim, illegal, fmt, opcode,
		input rd, rs1, rs2, funct3, funct7, imm
	);

endinterface

//--- verilog/rvc_mem_expander.sv
`timescale 1ns/1ns
`include "rvc_settings.svh"

module rvc_mem_expander
	import rvc_pkg::*;
#(
	parameter bit RV64 = `RVC_RV64_DEFAULT
) (
	input cinstr_t instr_i,
	rvc_expand_if.expander exp
);

	logic [1:0] quad;
	logic [2:0] f3;

	// full register fields, quadrant 2
	reg_idx_t rd_full;
	reg_idx_t rs2_full;

	// 3-bit register fields map onto x8..x15, quadrant 0
	reg_idx_t rd_c;
	reg_idx_t rs1_c;

	reg_idx_t sp_idx;
	reg_idx_t ra_idx;

	assign quad = instr_i[1:0];
	assign f3 = instr_i[15:13];

	assign rd_full = instr_i[11:7];
	assign rs2_full = instr_i[6:2];
	assign rd_c = {2'b01, instr_i[4:2]};
	assign rs1_c = {2'b01, instr_i[9:7]};

	assign sp_idx = reg_idx_t'(`RVC_SP_IDX);
	assign ra_idx = reg_idx_t'(`RVC_RA_IDX);

	always_comb begin
		exp.claim = (quad == 2'b00) || (quad == 2'b10);
		exp.illegal = 1'b0;
		exp.fmt = fmt_i;
		exp.opcode = opc_load;
		// width of every load and store follows f3[1:0]
		exp.funct3 = {1'b0, f3[1:0]};
		exp.funct7 = '0;
		exp.rd = '0;
		exp.rs1 = '0;
		exp.rs2 = '0;
		exp.imm = '0;

		if (quad == 2'b00) begin
			exp.rd = rd_c;
			exp.rs1 = rs1_c;
			exp.rs2 = rd_c;
			case (f3)
				3'b000: begin
					// c.addi4spn, offset scaled by 4
					exp.opcode = opc_op_imm;
					exp.rs1 = sp_idx;
					exp.imm = imm_t'({instr_i[10:7], instr_i[12:11], instr_i[5], instr_i[6], 2'b00});
					// all-zero word is the defined illegal instruction
					exp.illegal = (instr_i[12:2] == '0);
				end
				3'b010: begin
					// c.lw
					exp.imm = imm_t'({instr_i[5], instr_i[12:10], instr_i[6], 2'b00});
				end
				3'b011: begin
					// c.ld, flw slot on rv32
					exp.imm = imm_t'({instr_i[6:5], instr_i[12:10], 3'b000});
					exp.illegal = !RV64;
				end
				3'b110: begin
					// c.sw
					exp.fmt = fmt_s;
					exp.opcode = opc_store;
					exp.imm = imm_t'({instr_i[5], instr_i[12:10], instr_i[6], 2'b00});
				end
				3'b111: begin
					// c.sd, fsw slot on rv32
					exp.fmt = fmt_s;
					exp.opcode = opc_store;
					exp.imm = imm_t'({instr_i[6:5], instr_i[12:10], 3'b000});
					exp.illegal = !RV64;
				end
				// fld, fsd and the zcb slot
				default: exp.illegal = 1'b1;
			endcase
		end else if (quad == 2'b10) begin
			exp.rd = rd_full;
			exp.rs1 = sp_idx;
			exp.rs2 = rs2_full;
			case (f3)
				3'b000: begin
					// c.slli, shamt zero extended
					exp.opcode = opc_op_imm;
					exp.funct3 = 3'b001;
					exp.rs1 = rd_full;
					exp.imm = imm_t'({instr_i[12], instr_i[6:2]});
				end
				3'b010: begin
					// c.lwsp
					exp.imm = imm_t'({instr_i[3:2], instr_i[12], instr_i[6:4], 2'b00});
				end
				3'b011: begin
					// c.ldsp
					exp.imm = imm_t'({instr_i[4:2], instr_i[12], instr_i[6:5], 3'b000});
					exp.illegal = !RV64;
				end
				3'b100: begin
					if (rs2_full != '0) begin
						// c.mv reads x0, c.add reads rd
						exp.fmt = fmt_r;
						exp.opcode = opc_op;
						exp.rs1 = instr_i[12] ? rd_full : '0;
					end else if (rd_full != '0) begin
						// c.jr, c.jalr links through ra
						exp.opcode = opc_jalr;
						exp.rd = instr_i[12] ? ra_idx : '0;
						exp.rs1 = rd_full;
					end else begin
						// c.ebreak, jr x0 is reserved
						exp.opcode = opc_system;
						exp.rs1 = '0;
						exp.imm = imm_t'(1);
						exp.illegal = !instr_i[12];
					end
				end
				3'b110: begin
					// c.swsp
					exp.fmt = fmt_s;
					exp.opcode = opc_store;
					exp.imm = imm_t'({instr_i[8:7], instr_i[12:9], 2'b00});
				end
				3'b111: begin
					// c.sdsp
					exp.fmt = fmt_s;
					exp.opcode = opc_store;
					exp.imm = imm_t'({instr_i[9:7], instr_i[12:10], 3'b000});
					exp.illegal = !RV64;
				end
				// fldsp, fsdsp
				default: exp.illegal = 1'b1;
			endcase
		end
	end

endmodule

//--- verilog/rvc_pkg.sv
package rvc_pkg;

	`include "rvc_settings.svh"

	// major opcodes, bits [6:2] of a 32-bit instruction
	// low two bits are always 11 and live in the encoder
	typedef enum logic [4:0] {
		opc_load     = 5'b00000,
		opc_op_imm   = 5'b00100,
		opc_op_imm32 = 5'b00110,
		opc_store    = 5'b01000,
		opc_op       = 5'b01100,
		opc_lui      = 5'b01101,
		opc_op32     = 5'b01110,
		opc_branch   = 5'b11000,
		opc_jalr     = 5'b11001,
		opc_jal      = 5'b11011,
		opc_system   = 5'b11100
	} opcode_e;

	// instruction formats
	// picks how the encoder places the fields
	typedef enum logic [2:0] {
		fmt_r = 3'd0,
		fmt_i = 3'd1,
		fmt_s = 3'd2,
		fmt_b = 3'd3,
		fmt_u = 3'd4,
		fmt_j = 3'd5
	} format_e;

	// register index, x0 to x31
	typedef logic [4:0] reg_idx_t;

	typedef logic [2:0] funct3_t;

	typedef logic [6:0] funct7_t;

	// immediate container
	// I, S use [11:0], B holds offset[12:1] in [11:0]
	// U holds imm[31:12], J holds offset[20:1]
	typedef logic [19:0] imm_t;

	// full instruction or raw fetch word
	typedef logic [`RVC_FETCH_W-1:0] instr_t;

	// 16-bit compressed instruction
	typedef logic [`RVC_CINSTR_W-1:0] cinstr_t;

endpackage

//--- verilog/rvc_settings.svh
`ifndef RVC_SETTINGS_SVH
`define RVC_SETTINGS_SVH

// one fetch word, also the width of an expanded instruction
`define RVC_FETCH_W 32

// compressed instruction in the low half of the fetch word
`define RVC_CINSTR_W 16

// 1 decodes the RV64 slots, 0 the RV32 ones
`define RVC_RV64_DEFAULT 1

// x2, base of the stack relative loads and stores
`define RVC_SP_IDX 2

// x1, link register for c.jal and c.jalr
`define RVC_RA_IDX 1

`endif
